//--- mem_pkg.sv
// ====================
// shared types and address map of the memory controller
// program and data regions share one 4096-word memory
// ====================
package mem_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  sel_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [11:0] mem_idx_t;

    // store size codes, as in the RV32I store funct3
    localparam funct3_t F3_SB = 3'd0;
    localparam funct3_t F3_SH = 3'd1;
    localparam funct3_t F3_SW = 3'd2;

    // address map
    localparam addr_t PROG_BASE  = 32'h0000_0000;
    localparam addr_t PROG_BYTES = 32'h0000_2000;
    localparam addr_t DATA_BASE  = 32'h0000_2000;
    localparam addr_t DATA_BYTES = 32'h0000_2000;
    localparam int    MEM_WORDS  = 4096;

    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        addr_t adr;
        word_t dat;
    } wb_m2s_t;

    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_s2m_t;

    typedef struct packed {
        logic     en;
        logic     we;
        mem_idx_t idx;
        sel_t     sel;
        word_t    wdata;
    } mem_req_t;

    typedef enum logic [1:0] {PS_IDLE, PS_WAIT_GRANT, PS_DELAY, PS_ACK} port_state_e;
    typedef enum logic [1:0] {ARB_IDLE, ARB_DATA, ARB_FETCH} arb_state_e;

endpackage

//--- byte_mem.sv
// ====================
// simulation memory, zeroed then loaded from prog.hex
// one word per hex line, word 0 at address 0
// ====================
`timescale 1ns/1ps

module byte_mem import mem_pkg::*; (
    input  logic     clk,
    input  mem_req_t req,
    output word_t    rdata
);

    word_t mem [MEM_WORDS];

    // words beyond the end of the file stay zero
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
        $readmemh("prog.hex", mem);
    end

    // lane writes, little endian, byte b in bits 8b+7..8b
    always_ff @(posedge clk) begin
        if (req.en && req.we) begin
            for (int b = 0; b < 4; b++) begin
                if (req.sel[b]) begin
                    mem[req.idx][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
    end

    // asynchronous read
    assign rdata = mem[req.idx];

endmodule

//--- fetch_port.sv
// ====================
// instruction fetch slave, read only, DELAY must be at least 1
// master holds adr until ack, so adr is used without a copy
// ====================
`timescale 1ns/1ps

module fetch_port import mem_pkg::*; #(
    parameter int DELAY = 3
) (
    input  logic     clk,
    input  logic     rst_n,
    input  wb_m2s_t  bus_i,
    output wb_s2m_t  bus_o,
    output logic     req,
    input  logic     grant,
    output mem_req_t mreq,
    input  word_t    rdata
);

    localparam int CNT_W = (DELAY > 1) ? $clog2(DELAY) : 1;

    port_state_e      state;
    logic [CNT_W-1:0] cnt;
    addr_t            off;
    logic             in_range;
    logic             last;
    word_t            dat_q;

    // region check on the offset also covers the lower bound
    assign off      = bus_i.adr - PROG_BASE;
    assign in_range = off < PROG_BYTES;
    assign last     = (state == PS_DELAY) && (cnt == '0);

    // request goes up in the same cycle that stb is accepted
    assign req = ((state == PS_IDLE) && bus_i.cyc && bus_i.stb)
              || (state == PS_WAIT_GRANT) || (state == PS_DELAY);

    assign mreq = '{en: last && in_range, we: 1'b0, idx: mem_idx_t'(off >> 2),
                    sel: '0, wdata: '0};

    assign bus_o = '{ack: state == PS_ACK, dat: dat_q};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= PS_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                PS_IDLE:       if (bus_i.cyc && bus_i.stb) state <= PS_WAIT_GRANT;
                PS_WAIT_GRANT: if (grant) begin
                    state <= PS_DELAY;
                    cnt   <= CNT_W'(DELAY - 1);
                end
                PS_DELAY:      if (cnt == '0) state <= PS_ACK;
                               else cnt <= cnt - 1'b1;
                default:       state <= PS_IDLE;
            endcase
        end
    end

    // word captured on the last delay cycle, zero when out of region
    always_ff @(posedge clk) begin
        if (last) dat_q <= in_range ? rdata : '0;
    end

endmodule

//--- data_port.sv
// ====================
// load/store slave for the data region, DELAY must be at least 1
// SH and SW write the aligned word, only SB uses adr[1:0]
// ====================
`timescale 1ns/1ps

module data_port import mem_pkg::*; #(
    parameter int DELAY = 2
) (
    input  logic     clk,
    input  logic     rst_n,
    input  wb_m2s_t  bus_i,
    input  funct3_t  funct3,
    output wb_s2m_t  bus_o,
    output logic     req,
    input  logic     grant,
    output mem_req_t mreq,
    input  word_t    rdata
);

    localparam int CNT_W = (DELAY > 1) ? $clog2(DELAY) : 1;

    port_state_e      state;
    logic [CNT_W-1:0] cnt;
    addr_t            off;
    logic             in_range;
    logic             store_ok;
    logic             valid;
    logic             last;
    sel_t             sel;
    word_t            wdata;
    mem_idx_t         idx;
    word_t            dat_q;

    assign off      = bus_i.adr - DATA_BASE;
    assign in_range = off < DATA_BYTES;
    // data words sit after the program words
    assign idx      = mem_idx_t'(off >> 2) + mem_idx_t'(PROG_BYTES >> 2);

    // ====================
    // store lane decode
    // ====================
    always_comb begin
        store_ok = 1'b1;
        sel      = '0;
        wdata    = bus_i.dat;
        case (funct3)
            F3_SB: begin
                sel   = sel_t'(4'b0001 << bus_i.adr[1:0]);
                wdata = {4{bus_i.dat[7:0]}};
            end
            F3_SH: sel = 4'b0011;
            F3_SW: sel = 4'b1111;
            default: store_ok = 1'b0;
        endcase
    end

    // unsupported stores and stray addresses still run the sequence
    assign valid = in_range && (!bus_i.we || store_ok);
    assign last  = (state == PS_DELAY) && (cnt == '0);

    assign req = ((state == PS_IDLE) && bus_i.cyc && bus_i.stb)
              || (state == PS_WAIT_GRANT) || (state == PS_DELAY);

    assign mreq  = '{en: last && valid, we: bus_i.we, idx: idx, sel: sel, wdata: wdata};
    assign bus_o = '{ack: state == PS_ACK, dat: dat_q};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= PS_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                PS_IDLE:       if (bus_i.cyc && bus_i.stb) state <= PS_WAIT_GRANT;
                PS_WAIT_GRANT: if (grant) begin
                    state <= PS_DELAY;
                    cnt   <= CNT_W'(DELAY - 1);
                end
                PS_DELAY:      if (cnt == '0) state <= PS_ACK;
                               else cnt <= cnt - 1'b1;
                default:       state <= PS_IDLE;
            endcase
        end
    end

    // stores answer with zero
    always_ff @(posedge clk) begin
        if (last) dat_q <= (valid && !bus_i.we) ? rdata : '0;
    end

endmodule

//--- mem_arbiter.sv
// ====================
// one owner of the memory at a time, data before fetch
// a grant lasts until the owner drops its request
// ====================
`timescale 1ns/1ps

module mem_arbiter import mem_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     data_req,
    input  logic     fetch_req,
    input  mem_req_t data_mreq,
    input  mem_req_t fetch_mreq,
    output logic     data_grant,
    output logic     fetch_grant,
    output mem_req_t mreq
);

    arb_state_e state;
    arb_state_e state_nxt;

    // ====================
    // grant FSM
    // ====================
    always_comb begin
        state_nxt = state;
        case (state)
            ARB_IDLE: begin
                // data wins a tie
                if (data_req) begin
                    state_nxt = ARB_DATA;
                end else if (fetch_req) begin
                    state_nxt = ARB_FETCH;
                end
            end
            ARB_DATA: begin
                if (!data_req) state_nxt = ARB_IDLE;
            end
            ARB_FETCH: begin
                if (!fetch_req) state_nxt = ARB_IDLE;
            end
            default: state_nxt = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ARB_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // grants decode straight from the state register
    assign data_grant  = (state == ARB_DATA);
    assign fetch_grant = (state == ARB_FETCH);

    // ====================
    // request mux
    // ====================
    always_comb begin
        if (data_grant) begin
            mreq = data_mreq;
        end else if (fetch_grant) begin
            mreq = fetch_mreq;
        end else begin
            // idle, memory sees no enable
            mreq = '0;
        end
    end

endmodule

//--- mem_ctl_top.sv
// ====================
// two Wishbone classic slaves over one memory
// latency varies with contention, ack ends each access
// ====================
`timescale 1ns/1ps

module mem_ctl_top import mem_pkg::*; #(
    parameter int INSTR_FETCH_DELAY = 3,
    parameter int DATA_ACCESS_DELAY = 2
) (
    input  logic    clk,
    input  logic    rst_n,
    input  wb_m2s_t fetch_bus_i,
    output wb_s2m_t fetch_bus_o,
    input  wb_m2s_t data_bus_i,
    input  funct3_t data_funct3,
    output wb_s2m_t data_bus_o
);

    logic     fetch_req;
    logic     data_req;
    logic     fetch_grant;
    logic     data_grant;
    mem_req_t fetch_mreq;
    mem_req_t data_mreq;
    mem_req_t arb_mreq;
    word_t    mem_rdata;

    fetch_port #(.DELAY(INSTR_FETCH_DELAY)) u_fetch_port (
        .clk(clk), .rst_n(rst_n), .bus_i(fetch_bus_i), .bus_o(fetch_bus_o),
        .req(fetch_req), .grant(fetch_grant), .mreq(fetch_mreq), .rdata(mem_rdata)
    );

    data_port #(.DELAY(DATA_ACCESS_DELAY)) u_data_port (
        .clk(clk), .rst_n(rst_n), .bus_i(data_bus_i), .funct3(data_funct3),
        .bus_o(data_bus_o), .req(data_req), .grant(data_grant), .mreq(data_mreq),
        .rdata(mem_rdata)
    );

    // read data fans out to both ports
    mem_arbiter u_mem_arbiter (
        .clk(clk), .rst_n(rst_n), .data_req(data_req), .fetch_req(fetch_req),
        .data_mreq(data_mreq), .fetch_mreq(fetch_mreq), .data_grant(data_grant),
        .fetch_grant(fetch_grant), .mreq(arb_mreq)
    );

    byte_mem u_byte_mem (
        .clk(clk), .req(arb_mreq), .rdata(mem_rdata)
    );

endmodule

//--- mem_ctl_properties.sv
// ====================
// bound into mem_arbiter
// no checks while rst_n is low
// ====================
`timescale 1ns/1ps

module mem_ctl_properties import mem_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input logic     data_req,
    input logic     fetch_req,
    input mem_req_t data_mreq,
    input mem_req_t fetch_mreq,
    input logic     data_grant,
    input logic     fetch_grant
);

    int fails = 0;

    // memory enable only from the port that holds the grant
    a_one_owner: assert property (@(posedge clk) disable iff (!rst_n)
        (!data_mreq.en || data_grant) && (!fetch_mreq.en || fetch_grant))
        else begin
            $error("memory enable from a port without the grant");
            fails++;
        end

    // no preemption while the owner still requests
    a_data_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (data_grant && data_req) |=> data_grant)
        else begin
            $error("data grant dropped while data request high");
            fails++;
        end

    a_fetch_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (fetch_grant && fetch_req) |=> fetch_grant)
        else begin
            $error("fetch grant dropped while fetch request high");
            fails++;
        end

    a_data_cause: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(data_grant) |-> $past(data_req))
        else begin
            $error("data grant without a data request");
            fails++;
        end

    a_fetch_cause: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(fetch_grant) |-> $past(fetch_req))
        else begin
            $error("fetch grant without a fetch request");
            fails++;
        end

endmodule

bind mem_arbiter mem_ctl_properties u_mem_ctl_properties (.*);

//--- tb_mem_checker.sv
// ====================
// shadow memory loaded from prog.hex, compared on every ack cycle
// ====================
`timescale 1ns/1ps

module tb_mem_checker import mem_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  wb_m2s_t      fetch_bus_i,
    input  wb_s2m_t      fetch_bus_o,
    input  wb_m2s_t      data_bus_i,
    input  funct3_t      data_funct3,
    input  wb_s2m_t      data_bus_o,
    input  logic [127:0] fetch_name,
    input  logic [127:0] data_name,
    input  word_t        fetch_exp,
    input  word_t        data_exp,
    output int           checks,
    output int           errors
);

    word_t shadow [MEM_WORDS];

    initial begin
        checks = 0;
        errors = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = '0;
        end
        $readmemh("prog.hex", shadow);
    end

    task automatic check_word(input logic [127:0] name, input string src,
                              input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %0s (%0s): expected %h, actual %h", name, src, exp, act);
        end
    endtask

    always @(posedge clk) begin : watch
        word_t    model;
        addr_t    off;
        mem_idx_t idx;
        if (rst_n && fetch_bus_o.ack) begin
            off   = fetch_bus_i.adr - PROG_BASE;
            model = (off < PROG_BYTES) ? shadow[off >> 2] : '0;
            check_word(fetch_name, "table", fetch_exp, fetch_bus_o.dat);
            check_word(fetch_name, "model", model, fetch_bus_o.dat);
        end
        if (rst_n && data_bus_o.ack) begin
            off   = data_bus_i.adr - DATA_BASE;
            idx   = mem_idx_t'((off >> 2) + (PROG_BYTES >> 2));
            model = '0;
            // stores answer zero, stray addresses leave the shadow alone
            if (off < DATA_BYTES) begin
                if (!data_bus_i.we) begin
                    model = shadow[idx];
                end else if (data_funct3 == F3_SB) begin
                    shadow[idx][8*data_bus_i.adr[1:0] +: 8] = data_bus_i.dat[7:0];
                end else if (data_funct3 == F3_SH) begin
                    shadow[idx][15:0] = data_bus_i.dat[15:0];
                end else if (data_funct3 == F3_SW) begin
                    shadow[idx] = data_bus_i.dat;
                end
            end
            check_word(data_name, "table", data_exp, data_bus_o.dat);
            check_word(data_name, "model", model, data_bus_o.dat);
        end
    end

endmodule

//--- tb_mem_ctl.sv
// ====================
// drives both Wishbone ports from a table, default port delays
// needs prog.hex in the working directory
// ====================
`timescale 1ns/1ps

module tb_mem_ctl import mem_pkg::*; ();

    localparam int         TIMEOUT = 40;
    localparam logic [1:0] P_FETCH = 2'd0;
    localparam logic [1:0] P_LOAD  = 2'd1;
    localparam logic [1:0] P_STORE = 2'd2;

    typedef struct packed {
        logic [127:0] name;
        logic [1:0]   port;
        addr_t        adr;
        word_t        dat;
        funct3_t      f3;
        word_t        exp;
    } entry_t;

    logic         clk;
    logic         rst_n;
    wb_m2s_t      fetch_bus_i;
    wb_s2m_t      fetch_bus_o;
    wb_m2s_t      data_bus_i;
    wb_s2m_t      data_bus_o;
    funct3_t      data_funct3;
    logic [127:0] fetch_name;
    logic [127:0] data_name;
    word_t        fetch_exp;
    word_t        data_exp;
    int           checks;
    int           value_errors;
    int           run_errors;
    entry_t       tbl[$];

    mem_ctl_top u_mem_ctl_top (
        .clk(clk), .rst_n(rst_n), .fetch_bus_i(fetch_bus_i), .fetch_bus_o(fetch_bus_o),
        .data_bus_i(data_bus_i), .data_funct3(data_funct3), .data_bus_o(data_bus_o)
    );

    tb_mem_checker u_checker (
        .clk(clk), .rst_n(rst_n), .fetch_bus_i(fetch_bus_i), .fetch_bus_o(fetch_bus_o),
        .data_bus_i(data_bus_i), .data_funct3(data_funct3), .data_bus_o(data_bus_o),
        .fetch_name(fetch_name), .data_name(data_name), .fetch_exp(fetch_exp),
        .data_exp(data_exp), .checks(checks), .errors(value_errors)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic add_entry(input logic [127:0] name, input logic [1:0] port,
                             input addr_t adr, input word_t dat, input funct3_t f3,
                             input word_t exp);
        tbl.push_back('{name, port, adr, dat, f3, exp});
    endtask

    // ====================
    // stimulus table
    // ====================
    task automatic build_table();
        word_t w;
        word_t b;
        add_entry("fetch_w0", P_FETCH, 32'h0000, '0, F3_SW, 32'h0000_0093);
        add_entry("fetch_w10", P_FETCH, 32'h0028, '0, F3_SW, 32'hdead_beef);
        add_entry("fetch_w15", P_FETCH, 32'h003c, '0, F3_SW, 32'h0000_8067);
        add_entry("fetch_last", P_FETCH, 32'h1ffc, '0, F3_SW, '0);
        add_entry("fetch_oob", P_FETCH, 32'h4000, '0, F3_SW, '0);
        add_entry("sw_store", P_STORE, 32'h2000, 32'hcafe_1234, F3_SW, '0);
        add_entry("sw_load", P_LOAD, 32'h2000, '0, F3_SW, 32'hcafe_1234);
        add_entry("load_oob", P_LOAD, 32'h1000, '0, F3_SW, '0);
        // one lane per byte store, upper bits of dat are noise
        w = $urandom;
        add_entry("sb_base", P_STORE, 32'h2010, w, F3_SW, '0);
        for (int k = 0; k < 4; k++) begin
            b = $urandom;
            w[8*k +: 8] = b[7:0];
            add_entry({"sb_st", 8'h30 + 8'(k)}, P_STORE, 32'h2010 + k, b, F3_SB, '0);
            add_entry({"sb_ld", 8'h30 + 8'(k)}, P_LOAD, 32'h2010, '0, F3_SW, w);
        end
        w = $urandom;
        add_entry("sh_base", P_STORE, 32'h2014, w, F3_SW, '0);
        b = $urandom;
        w[15:0] = b[15:0];
        add_entry("sh_st", P_STORE, 32'h2014, b, F3_SH, '0);
        add_entry("sh_ld", P_LOAD, 32'h2014, '0, F3_SW, w);
        // halfword at offset 2 still lands in the low lanes
        b = $urandom;
        w[15:0] = b[15:0];
        add_entry("sh_st_hi", P_STORE, 32'h2016, b, F3_SH, '0);
        add_entry("sh_ld_hi", P_LOAD, 32'h2014, '0, F3_SW, w);
        add_entry("bad_f3_st", P_STORE, 32'h2014, 32'hffff_ffff, 3'd3, '0);
        add_entry("bad_f3_ld", P_LOAD, 32'h2014, '0, F3_SW, w);
    endtask

    task automatic drive_entry(input entry_t e);
        if (e.port == P_FETCH) begin
            fetch_bus_i = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: e.adr, dat: '0};
            fetch_name  = e.name;
            fetch_exp   = e.exp;
        end else begin
            data_bus_i  = '{cyc: 1'b1, stb: 1'b1, we: e.port == P_STORE, adr: e.adr, dat: e.dat};
            data_funct3 = e.f3;
            data_name   = e.name;
            data_exp    = e.exp;
        end
    endtask

    // cycle numbers of each ack, counted from the drive edge
    task automatic wait_acks(input logic f_on, input logic d_on, output int f_at, output int d_at);
        int   cyc;
        logic f_done;
        logic d_done;
        cyc    = 0;
        f_at   = 0;
        d_at   = 0;
        f_done = !f_on;
        d_done = !d_on;
        while (!(f_done && d_done) && cyc < TIMEOUT) begin
            @(negedge clk);
            cyc++;
            // stb drops in the cycle after ack
            if (f_done) fetch_bus_i = '0;
            if (d_done) data_bus_i = '0;
            if (!f_done && fetch_bus_o.ack) begin
                f_done = 1'b1;
                f_at   = cyc;
            end
            if (!d_done && data_bus_o.ack) begin
                d_done = 1'b1;
                d_at   = cyc;
            end
        end
        if (!f_done) begin
            run_errors++;
            $display("timeout: no ack on the fetch port in test %0s", fetch_name);
        end
        if (!d_done) begin
            run_errors++;
            $display("timeout: no ack on the data port in test %0s", data_name);
        end
        @(negedge clk);
        fetch_bus_i = '0;
        data_bus_i  = '0;
    endtask

    initial begin
        int f_at;
        int d_at;
        int asrt;
        void'($urandom(76));
        rst_n       = 1'b0;
        fetch_bus_i = '0;
        data_bus_i  = '0;
        data_funct3 = '0;
        fetch_name  = '0;
        data_name   = '0;
        fetch_exp   = '0;
        data_exp    = '0;
        run_errors  = 0;
        build_table();
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        if (fetch_bus_o.ack || data_bus_o.ack) begin
            run_errors++;
            $display("an ack is high right after reset");
        end

        foreach (tbl[i]) begin
            @(negedge clk);
            drive_entry(tbl[i]);
            wait_acks(tbl[i].port == P_FETCH, tbl[i].port != P_FETCH, f_at, d_at);
        end

        // ====================
        // data against fetch
        // ====================
        @(negedge clk);
        drive_entry('{"prio_fetch", P_FETCH, 32'h002c, '0, F3_SW, 32'h1234_5678});
        drive_entry('{"prio_load", P_LOAD, 32'h2000, '0, F3_SW, 32'hcafe_1234});
        wait_acks(1'b1, 1'b1, f_at, d_at);
        if (f_at != 0 && d_at != 0 && d_at >= f_at) begin
            run_errors++;
            $display("data ack at cycle %0d did not come before fetch ack at cycle %0d",
                     d_at, f_at);
        end

        @(negedge clk);
        // two compares per ack
        if (checks != 2 * (tbl.size() + 2)) begin
            run_errors++;
            $display("checker saw %0d compares instead of %0d", checks, 2 * (tbl.size() + 2));
        end
        asrt = u_mem_ctl_top.u_mem_arbiter.u_mem_ctl_properties.fails;
        $display("checks %0d, value errors %0d, run errors %0d, assertion failures %0d",
                 checks, value_errors, run_errors, asrt);
        if (value_errors == 0 && run_errors == 0 && asrt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- prog.hex
// one 32-bit word per line in hex, word 0 at byte address 0
// words past the last line read as zero
00000093
00100113
002081b3
00002237
00322023
00022283
00510333
0062a223
00418393
fe7ff06f
deadbeef
12345678
a5a5a5a5
0badf00d
00000013
00008067

//--- build.f
mem_pkg.sv
byte_mem.sv
fetch_port.sv
data_port.sv
mem_arbiter.sv
mem_ctl_top.sv
mem_ctl_properties.sv
tb_mem_checker.sv
tb_mem_ctl.sv

//--- Bender.yml
package:
  name: mem_ctl

sources:
  - mem_pkg.sv
  - byte_mem.sv
  - fetch_port.sv
  - data_port.sv
  - mem_arbiter.sv
  - mem_ctl_top.sv
  - target: test
    files:
      - mem_ctl_properties.sv
      - tb_mem_checker.sv
      - tb_mem_ctl.sv
